// File: hw/frogger_pkg.sv
// frogger colour mapper shared definitions
// screen and colour types, object geometry, flat object and scenery colours

package frogger_pkg;

	// ----------------------------------------
	// types
	// ----------------------------------------
	typedef logic [10:0] coord_t;
	typedef logic [7:0]  chan_t;
	// red in the top byte, blue in the bottom
	typedef logic [23:0] rgb_t;
	typedef logic [2:0]  count_t;

	// lane sizes
	localparam int N_LANES = 4;
	localparam int N_OBJ   = 4;

	// ----------------------------------------
	// object geometry
	// ----------------------------------------
	localparam int CAR_W  = 80;
	localparam int CAR_H  = 40;
	localparam int LPAD_W = 40;
	localparam int LPAD_H = 40;
	localparam int FROG_W = 40;
	localparam int FROG_H = 40;

	// hit box of the frog is smaller than its cell
	localparam int FROG_INSET_X   = 7;
	localparam int FROG_INSET_TOP = 10;
	localparam int FROG_INSET_BOT = 5;

	// objects at or past this x came round from the left edge
	localparam coord_t WRAP_X = 11'd680;

	// ----------------------------------------
	// colours
	// ----------------------------------------
	localparam rgb_t FROG_RGB       = {chan_t'(50),  chan_t'(205), chan_t'(50)};
	localparam rgb_t CAR_R_RGB      = {chan_t'(200), chan_t'(0),   chan_t'(0)};
	localparam rgb_t CAR_L_RGB      = {chan_t'(0),   chan_t'(0),   chan_t'(200)};
	localparam rgb_t LPAD_RGB       = {chan_t'(0),   chan_t'(250), chan_t'(0)};
	localparam rgb_t WATER_RGB      = {chan_t'(0),   chan_t'(200), chan_t'(255)};
	localparam rgb_t DARK_GRASS_RGB = {chan_t'(0),   chan_t'(100), chan_t'(0)};
	localparam rgb_t GRASS_RGB      = {chan_t'(0),   chan_t'(200), chan_t'(0)};
	localparam rgb_t MARK_RGB       = {chan_t'(255), chan_t'(204), chan_t'(0)};
	localparam rgb_t PAVE_RGB       = {chan_t'(69),  chan_t'(69),  chan_t'(69)};
	localparam rgb_t WHITE_RGB      = {chan_t'(255), chan_t'(255), chan_t'(255)};

endpackage

// File: hw/pixel_if.sv
// hit-tested pixel bus
// carries one pixel and its object hit flags from the hit stage to the compositor

interface pixel_if #(
	parameter int N_LANES = frogger_pkg::N_LANES
);
	import frogger_pkg::*;

	logic               valid;
	coord_t             x;
	coord_t             y;
	logic               frog_hit;
	// one flag per car lane, lane 1 in bit 0
	logic [N_LANES-1:0] car_hit;
	// any lily pad in any lane
	logic               lpad_hit;

	modport hit (
		output valid,
		output x,
		output y,
		output frog_hit,
		output car_hit,
		output lpad_hit
	);

	modport comp (
		input valid,
		input x,
		input y,
		input frog_hit,
		input car_hit,
		input lpad_hit
	);

endinterface

// File: hw/lane_hit.sv
// lane hit test
// checks one lane of moving objects against the pixel, wrapped objects included

module lane_hit #(
	parameter int N_OBJ = frogger_pkg::N_OBJ,
	parameter int OBJ_W = frogger_pkg::CAR_W,
	parameter int OBJ_H = frogger_pkg::CAR_H
) (
	input  frogger_pkg::coord_t             draw_x,
	input  frogger_pkg::coord_t             draw_y,
	input  frogger_pkg::coord_t [N_OBJ-1:0] obj_x,
	input  frogger_pkg::coord_t             lane_y,
	input  frogger_pkg::count_t             count,
	output logic                            hit
);
	import frogger_pkg::*;

	coord_t             bot_y;
	logic               y_in;
	logic [N_OBJ-1:0]   obj_hit;

	// all objects of a lane share one row
	assign bot_y = lane_y + coord_t'(OBJ_H);
	assign y_in  = (draw_y >= lane_y) && (draw_y <= bot_y);

	for (genvar k = 0; k < N_OBJ; k++)
	begin : g_obj
		coord_t right_x;
		logic   live;
		logic   wrapped;
		logic   x_in;

		// right edge wraps modulo 2048
		assign right_x = obj_x[k] + coord_t'(OBJ_W);
		assign live    = (int'(count) > k);
		assign wrapped = (obj_x[k] >= WRAP_X);

		// a wrapped object only shows its tail from the left edge
		assign x_in = wrapped ? (draw_x <= right_x)
				: ((draw_x >= obj_x[k]) && (draw_x <= right_x));

		assign obj_hit[k] = live && x_in && y_in;
	end

	assign hit = |obj_hit;

endmodule

// File: hw/object_hit_stage.sv
// object hit stage
// first pipeline stage: tests frog, car lanes and lily-pad lanes against
// the sampled pixel and registers the hit flags

module object_hit_stage #(
	parameter int N_LANES = frogger_pkg::N_LANES,
	parameter int N_OBJ   = frogger_pkg::N_OBJ
) (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic                                            pixel_valid,
	input  frogger_pkg::coord_t                             draw_x,
	input  frogger_pkg::coord_t                             draw_y,
	input  frogger_pkg::coord_t                             frog_x,
	input  frogger_pkg::coord_t                             frog_y,
	input  frogger_pkg::coord_t [N_LANES-1:0][N_OBJ-1:0]    car_x,
	input  frogger_pkg::coord_t [N_LANES-1:0]               car_y,
	input  frogger_pkg::count_t [N_LANES-1:0]               car_count,
	input  frogger_pkg::coord_t [N_LANES-1:0][N_OBJ-1:0]    lpad_x,
	input  frogger_pkg::coord_t [N_LANES-1:0]               lpad_y,
	input  frogger_pkg::count_t [N_LANES-1:0]               lpad_count,
	pixel_if.hit                                            out
);
	import frogger_pkg::*;

	coord_t             frog_l;
	coord_t             frog_r;
	coord_t             frog_t;
	coord_t             frog_b;
	logic               frog_hit_c;
	logic [N_LANES-1:0] car_hit_c;
	logic [N_LANES-1:0] lpad_lane_hit;
	logic               counts_ok;

	// ----------------------------------------
	// frog hit box
	// ----------------------------------------
	assign frog_l = frog_x + coord_t'(FROG_INSET_X);
	assign frog_r = frog_x + coord_t'(FROG_W - FROG_INSET_X);
	assign frog_t = frog_y + coord_t'(FROG_INSET_TOP);
	assign frog_b = frog_y + coord_t'(FROG_H - FROG_INSET_BOT);

	assign frog_hit_c = (draw_x >= frog_l) && (draw_x <= frog_r) &&
			(draw_y >= frog_t) && (draw_y <= frog_b);

	// ----------------------------------------
	// lanes
	// ----------------------------------------
	for (genvar l = 0; l < N_LANES; l++)
	begin : g_lane
		lane_hit #(
			.N_OBJ (N_OBJ),
			.OBJ_W (CAR_W),
			.OBJ_H (CAR_H)
		) u_car (
			.draw_x (draw_x),
			.draw_y (draw_y),
			.obj_x  (car_x[l]),
			.lane_y (car_y[l]),
			.count  (car_count[l]),
			.hit    (car_hit_c[l])
		);

		lane_hit #(
			.N_OBJ (N_OBJ),
			.OBJ_W (LPAD_W),
			.OBJ_H (LPAD_H)
		) u_pad (
			.draw_x (draw_x),
			.draw_y (draw_y),
			.obj_x  (lpad_x[l]),
			.lane_y (lpad_y[l]),
			.count  (lpad_count[l]),
			.hit    (lpad_lane_hit[l])
		);
	end

	// stage register, payload only moves with a pixel
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out.valid <= 1'b0;
		else
			out.valid <= pixel_valid;

		if (pixel_valid)
		begin
			out.x        <= draw_x;
			out.y        <= draw_y;
			out.frog_hit <= frog_hit_c;
			out.car_hit  <= car_hit_c;
			out.lpad_hit <= |lpad_lane_hit;
		end
	end

	// counts beyond the lane size would point at missing objects
	always_comb
	begin
		counts_ok = 1'b1;
		for (int l = 0; l < N_LANES; l++)
		begin
			if (int'(car_count[l]) > N_OBJ || int'(lpad_count[l]) > N_OBJ)
				counts_ok = 1'b0;
		end
	end

	a_count_range : assert property (@(posedge clk) disable iff (!rst_n)
			pixel_valid |-> counts_ok)
		else $error("lane count above %0d objects", N_OBJ);

endmodule

// File: hw/background_map.sv
// background scenery map
// maps a pixel position to water, grass, lane marks, pavement or white

module background_map (
	input  frogger_pkg::coord_t x,
	input  frogger_pkg::coord_t y,
	output frogger_pkg::rgb_t   rgb
);
	import frogger_pkg::*;

	logic water;
	logic bank_row;
	logic dark_col;
	logic grass_col;
	logic grass;
	logic mark_row;
	logic mark_col;
	logic pave;

	// river band
	assign water = (y >= 11'd80) && (y <= 11'd239);

	// ----------------------------------------
	// top bank with home notches
	// ----------------------------------------
	assign bank_row = (y >= 11'd40) && (y <= 11'd79);

	assign dark_col = (x <= 11'd119) ||
			((x >= 11'd160) && (x <= 11'd279)) ||
			((x >= 11'd320) && (x <= 11'd479)) ||
			((x >= 11'd520) && (x <= 11'd679));

	assign grass_col = ((x >= 11'd120) && (x <= 11'd159)) ||
			((x >= 11'd280) && (x <= 11'd319)) ||
			((x >= 11'd480) && (x <= 11'd519));

	// median strip, start strip and the gaps in the bank
	assign grass = ((y >= 11'd240) && (y <= 11'd279)) ||
			(y >= 11'd440) ||
			(bank_row && grass_col);

	// ----------------------------------------
	// road
	// ----------------------------------------
	// dashed marks between the car lanes
	assign mark_row = ((y >= 11'd318) && (y <= 11'd322)) ||
			((y >= 11'd358) && (y <= 11'd362)) ||
			((y >= 11'd398) && (y <= 11'd402));

	assign mark_col = (x <= 11'd100) ||
			((x >= 11'd200) && (x <= 11'd300)) ||
			((x >= 11'd400) && (x <= 11'd500)) ||
			(x >= 11'd600);

	assign pave = (y >= 11'd280) && (y <= 11'd439);

	// first match wins
	always_comb
	begin
		if (water)
			rgb = WATER_RGB;
		else if (bank_row && dark_col)
			rgb = DARK_GRASS_RGB;
		else if (grass)
			rgb = GRASS_RGB;
		else if (mark_row && mark_col)
			rgb = MARK_RGB;
		else if (pave)
			rgb = PAVE_RGB;
		else
			rgb = WHITE_RGB;
	end

endmodule

// File: hw/pixel_compositor.sv
// pixel compositor
// second pipeline stage: picks the top layer at the pixel and registers
// the colour

module pixel_compositor #(
	parameter int N_LANES = frogger_pkg::N_LANES
) (
	input  logic              clk,
	input  logic              rst_n,
	pixel_if.comp             in,
	output logic              rgb_valid,
	output frogger_pkg::rgb_t rgb
);
	import frogger_pkg::*;

	rgb_t bg_rgb;
	rgb_t pick;

	background_map u_bg (
		.x   (in.x),
		.y   (in.y),
		.rgb (bg_rgb)
	);

	// ----------------------------------------
	// layer priority
	// ----------------------------------------
	// later assignments win, so layers go bottom up
	always_comb
	begin
		pick = bg_rgb;
		if (in.lpad_hit)
			pick = LPAD_RGB;

		// lane 1 last so it beats the lanes below it
		for (int i = N_LANES - 1; i >= 0; i--)
		begin
			if (in.car_hit[i])
				pick = (i % 2 == 0) ? CAR_R_RGB : CAR_L_RGB;
		end

		if (in.frog_hit)
			pick = FROG_RGB;
	end

	// output register
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rgb_valid <= 1'b0;
			rgb       <= '0;
		end
		else
		begin
			rgb_valid <= in.valid;
			if (in.valid)
				rgb <= pick;
		end
	end

	// a colour leaving the pipe must have been fully resolved upstream
	a_rgb_known : assert property (@(posedge clk) disable iff (!rst_n)
			rgb_valid |-> !$isunknown(rgb))
		else $error("unknown colour on a valid pixel");

endmodule

// File: hw/color_mapper.sv
// frogger colour mapper top level
// samples a pixel on a strobe and returns its colour two cycles later
// through the hit stage and the compositor

module color_mapper #(
	parameter int N_LANES = frogger_pkg::N_LANES,
	parameter int N_OBJ   = frogger_pkg::N_OBJ
) (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic                                            pixel_valid,
	input  frogger_pkg::coord_t                             draw_x,
	input  frogger_pkg::coord_t                             draw_y,
	input  frogger_pkg::coord_t                             frog_x,
	input  frogger_pkg::coord_t                             frog_y,
	input  frogger_pkg::coord_t [N_LANES-1:0][N_OBJ-1:0]    car_x,
	input  frogger_pkg::coord_t [N_LANES-1:0]               car_y,
	input  frogger_pkg::count_t [N_LANES-1:0]               car_count,
	input  frogger_pkg::coord_t [N_LANES-1:0][N_OBJ-1:0]    lpad_x,
	input  frogger_pkg::coord_t [N_LANES-1:0]               lpad_y,
	input  frogger_pkg::count_t [N_LANES-1:0]               lpad_count,
	output logic                                            rgb_valid,
	output frogger_pkg::rgb_t                               rgb
);

	// ----------------------------------------
	// stage link
	// ----------------------------------------
	pixel_if #(
		.N_LANES (N_LANES)
	) px ();

	// stage 1, hit tests
	object_hit_stage #(
		.N_LANES (N_LANES),
		.N_OBJ   (N_OBJ)
	) u_hit (
		.clk         (clk),
		.rst_n       (rst_n),
		.pixel_valid (pixel_valid),
		.draw_x      (draw_x),
		.draw_y      (draw_y),
		.frog_x      (frog_x),
		.frog_y      (frog_y),
		.car_x       (car_x),
		.car_y       (car_y),
		.car_count   (car_count),
		.lpad_x      (lpad_x),
		.lpad_y      (lpad_y),
		.lpad_count  (lpad_count),
		.out         (px.hit)
	);

	// stage 2, layer pick and colour
	pixel_compositor #(
		.N_LANES (N_LANES)
	) u_comp (
		.clk       (clk),
		.rst_n     (rst_n),
		.in        (px.comp),
		.rgb_valid (rgb_valid),
		.rgb       (rgb)
	);

endmodule

// File: tb/color_mapper_tb.sv
// colour mapper testbench
// table of frog, lane and scenery cases plus a random background sweep,
// checked against the two-cycle pipeline timing

module color_mapper_tb;
	import frogger_pkg::*;

	localparam int FAR    = 1000;
	localparam int N_RAND = 64;

	// one table case with a single lane setup for a car lane, a pad lane or both
	typedef struct packed {
		coord_t              fx;
		coord_t              fy;
		int                  car_lane;
		int                  pad_lane;
		coord_t              ly;
		coord_t [N_OBJ-1:0]  ox;
		count_t              cnt;
		coord_t              px;
		coord_t              py;
		rgb_t                exp;
	} row_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		rgb_t   exp;
	} flight_t;

	logic                               clk;
	logic                               rst_n;
	logic                               pixel_valid;
	coord_t                             draw_x;
	coord_t                             draw_y;
	coord_t                             frog_x;
	coord_t                             frog_y;
	coord_t [N_LANES-1:0][N_OBJ-1:0]    car_x;
	coord_t [N_LANES-1:0]               car_y;
	count_t [N_LANES-1:0]               car_count;
	coord_t [N_LANES-1:0][N_OBJ-1:0]    lpad_x;
	coord_t [N_LANES-1:0]               lpad_y;
	count_t [N_LANES-1:0]               lpad_count;
	logic                               rgb_valid;
	rgb_t                               rgb;

	row_t        rows[$];
	flight_t     in_flight[$];
	logic [1:0]  hist = 2'b00;
	logic [31:0] lfsr = 32'h2430;
	int          rgb_errs = 0;
	int          valid_errs = 0;
	int          n_sent = 0;
	int          n_checked = 0;
	int          cycle_cnt = 0;
	int          cycle_limit = 1000;

	color_mapper #(
		.N_LANES (N_LANES),
		.N_OBJ   (N_OBJ)
	) dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.pixel_valid (pixel_valid),
		.draw_x      (draw_x),
		.draw_y      (draw_y),
		.frog_x      (frog_x),
		.frog_y      (frog_y),
		.car_x       (car_x),
		.car_y       (car_y),
		.car_count   (car_count),
		.lpad_x      (lpad_x),
		.lpad_y      (lpad_y),
		.lpad_count  (lpad_count),
		.rgb_valid   (rgb_valid),
		.rgb         (rgb)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------
	// reference model and helpers
	// ----------------------------------------
	// scenery rule where the first match wins
	function automatic rgb_t bg_ref(input int x, input int y);
		bit bank;
		bit notch;
		bit mark_row;
		bit mark_col;
		bank     = (y >= 40) && (y < 80);
		notch    = (x >= 120 && x < 160) || (x >= 280 && x < 320) ||
				(x >= 480 && x < 520);
		mark_row = (y >= 318 && y <= 322) || (y >= 358 && y <= 362) ||
				(y >= 398 && y <= 402);
		mark_col = (x <= 100) || (x >= 200 && x <= 300) ||
				(x >= 400 && x <= 500) || (x >= 600);
		if (y >= 80 && y < 240)
			return WATER_RGB;
		if (bank && x < 680 && !notch)
			return DARK_GRASS_RGB;
		if ((y >= 240 && y < 280) || (y >= 440) || (bank && notch))
			return GRASS_RGB;
		if (mark_row && mark_col)
			return MARK_RGB;
		if (y >= 280 && y < 440)
			return PAVE_RGB;
		return WHITE_RGB;
	endfunction

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic add_row(input int fx, fy, car_l, pad_l, ly, ox0, ox1, cnt, px, py,
			input rgb_t exp);
		row_t r;
		r          = '0;
		r.fx       = coord_t'(fx);
		r.fy       = coord_t'(fy);
		r.car_lane = car_l;
		r.pad_lane = pad_l;
		r.ly       = coord_t'(ly);
		r.ox[0]    = coord_t'(ox0);
		r.ox[1]    = coord_t'(ox1);
		r.cnt      = count_t'(cnt);
		r.px       = coord_t'(px);
		r.py       = coord_t'(py);
		r.exp      = exp;
		rows.push_back(r);
	endtask

	task automatic bg_row(input int px, py, input rgb_t exp);
		add_row(FAR, FAR, -1, -1, 0, 0, 0, 0, px, py, exp);
	endtask

	// empty lanes and the frog off screen
	task automatic clear_scene();
		frog_x     <= coord_t'(FAR);
		frog_y     <= coord_t'(FAR);
		car_x      <= '0;
		car_y      <= '0;
		car_count  <= '0;
		lpad_x     <= '0;
		lpad_y     <= '0;
		lpad_count <= '0;
	endtask

	task automatic send_pixel(input coord_t x, input coord_t y, input rgb_t exp);
		flight_t f;
		f.x = x;
		f.y = y;
		f.exp = exp;
		pixel_valid <= 1'b1;
		draw_x      <= x;
		draw_y      <= y;
		in_flight.push_back(f);
		n_sent++;
	endtask

	task automatic apply_row(input row_t r);
		clear_scene();
		frog_x <= r.fx;
		frog_y <= r.fy;
		if (r.car_lane >= 0)
		begin
			car_x[r.car_lane]     <= r.ox;
			car_y[r.car_lane]     <= r.ly;
			car_count[r.car_lane] <= r.cnt;
		end
		if (r.pad_lane >= 0)
		begin
			lpad_x[r.pad_lane]     <= r.ox;
			lpad_y[r.pad_lane]     <= r.ly;
			lpad_count[r.pad_lane] <= r.cnt;
		end
		send_pixel(r.px, r.py, r.exp);
	endtask

	task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
		if (got !== exp)
		begin
			rgb_errs++;
			$display("ERR %0t: %s gave rgb %06h, expected %06h",
					$time, what, got, exp);
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp)
		begin
			valid_errs++;
			$display("ERR %0t: rgb_valid is %b, expected %b", $time, got, exp);
		end
	endtask

	// ----------------------------------------
	// output monitor
	// ----------------------------------------
	// rgb_valid follows the strobe by two cycles
	always @(negedge clk)
	begin
		flight_t f;
		if (rst_n)
		begin
			check_valid(rgb_valid, hist[1]);
			if (rgb_valid)
			begin
				if (in_flight.size() == 0)
				begin
					valid_errs++;
					$display("rgb_valid rose at %0t with no pixel in flight", $time);
				end
				else
				begin
					f = in_flight.pop_front();
					n_checked++;
					check_rgb(rgb, f.exp, $sformatf("pixel (%0d,%0d)", f.x, f.y));
				end
			end
		end
		hist <= {hist[0], pixel_valid};
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial
	begin
		int v;
		coord_t px;
		coord_t py;

		// frog box edges over pavement
		add_row(150, 280, -1, -1, 0, 0, 0, 0, 157, 300, FROG_RGB);
		add_row(150, 280, -1, -1, 0, 0, 0, 0, 183, 300, FROG_RGB);
		add_row(150, 280, -1, -1, 0, 0, 0, 0, 170, 290, FROG_RGB);
		add_row(150, 280, -1, -1, 0, 0, 0, 0, 170, 315, FROG_RGB);
		add_row(150, 280, -1, -1, 0, 0, 0, 0, 156, 300, PAVE_RGB);
		add_row(150, 280, -1, -1, 0, 0, 0, 0, 184, 300, PAVE_RGB);
		add_row(150, 280, -1, -1, 0, 0, 0, 0, 170, 289, PAVE_RGB);
		add_row(150, 280, -1, -1, 0, 0, 0, 0, 170, 316, PAVE_RGB);
		// car edges with the second object dead at count 1
		add_row(FAR, FAR, 0, -1, 320, 100, 300, 1, 100, 320, CAR_R_RGB);
		add_row(FAR, FAR, 0, -1, 320, 100, 300, 1, 180, 360, CAR_R_RGB);
		add_row(FAR, FAR, 0, -1, 320, 100, 300, 1, 181, 340, PAVE_RGB);
		add_row(FAR, FAR, 0, -1, 320, 100, 300, 1, 99, 340, PAVE_RGB);
		add_row(FAR, FAR, 0, -1, 320, 100, 300, 1, 320, 340, PAVE_RGB);
		add_row(FAR, FAR, 0, -1, 320, 100, 300, 2, 320, 340, CAR_R_RGB);
		add_row(FAR, FAR, 1, -1, 320, 100, 300, 1, 150, 340, CAR_L_RGB);
		add_row(FAR, FAR, 2, -1, 320, 100, 300, 1, 150, 340, CAR_R_RGB);
		add_row(FAR, FAR, 3, -1, 320, 100, 300, 1, 150, 340, CAR_L_RGB);
		// wrapped car reaches x 72
		add_row(FAR, FAR, 1, -1, 320, 2040, 0, 1, 0, 340, CAR_L_RGB);
		add_row(FAR, FAR, 1, -1, 320, 2040, 0, 1, 72, 340, CAR_L_RGB);
		add_row(FAR, FAR, 1, -1, 320, 2040, 0, 1, 73, 340, PAVE_RGB);
		add_row(FAR, FAR, 1, -1, 320, 2040, 0, 1, 50, 360, CAR_L_RGB);
		add_row(FAR, FAR, 1, -1, 320, 2040, 0, 1, 50, 361, MARK_RGB);
		// layer priority
		add_row(100, 320, 0, -1, 320, 100, 0, 1, 120, 340, FROG_RGB);
		add_row(FAR, FAR, 1, 1, 120, 200, 0, 1, 210, 130, CAR_L_RGB);
		add_row(FAR, FAR, -1, 0, 120, 200, 0, 1, 210, 130, LPAD_RGB);
		add_row(FAR, FAR, -1, 0, 120, 200, 0, 1, 240, 160, LPAD_RGB);
		add_row(FAR, FAR, -1, 0, 120, 200, 0, 1, 241, 130, WATER_RGB);
		add_row(FAR, FAR, -1, 3, 120, 200, 0, 1, 220, 150, LPAD_RGB);
		// scenery regions and boundaries
		bg_row(10, 39, WHITE_RGB);
		bg_row(10, 40, DARK_GRASS_RGB);
		bg_row(119, 79, DARK_GRASS_RGB);
		bg_row(120, 60, GRASS_RGB);
		bg_row(159, 60, GRASS_RGB);
		bg_row(160, 60, DARK_GRASS_RGB);
		bg_row(519, 60, GRASS_RGB);
		bg_row(679, 60, DARK_GRASS_RGB);
		bg_row(680, 60, WHITE_RGB);
		bg_row(10, 80, WATER_RGB);
		bg_row(639, 239, WATER_RGB);
		bg_row(10, 240, GRASS_RGB);
		bg_row(10, 280, PAVE_RGB);
		bg_row(100, 322, MARK_RGB);
		bg_row(101, 320, PAVE_RGB);
		bg_row(300, 398, MARK_RGB);
		bg_row(599, 400, PAVE_RGB);
		bg_row(600, 402, MARK_RGB);
		bg_row(10, 439, PAVE_RGB);
		bg_row(639, 440, GRASS_RGB);

		cycle_limit = 8 + rows.size() + N_RAND + 20;

		rst_n       = 1'b0;
		pixel_valid = 1'b0;
		draw_x      = '0;
		draw_y      = '0;
		frog_x      = coord_t'(FAR);
		frog_y      = coord_t'(FAR);
		car_x       = '0;
		car_y       = '0;
		car_count   = '0;
		lpad_x      = '0;
		lpad_y      = '0;
		lpad_count  = '0;

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		// idle with no strobe
		repeat (4) @(posedge clk);
		// colour register still holds its reset value
		@(negedge clk);
		check_rgb(rgb, '0, "idle output after reset");

		foreach (rows[i])
		begin
			@(posedge clk);
			apply_row(rows[i]);
		end
		@(posedge clk);
		pixel_valid <= 1'b0;
		@(posedge clk);

		// random sweep with a gap every eighth cycle
		for (int i = 0; i < N_RAND; i++)
		begin
			@(posedge clk);
			clear_scene();
			take_bits(10, v);
			px = coord_t'(v % 640);
			take_bits(9, v);
			py = coord_t'(v % 480);
			if (i % 8 == 7)
				pixel_valid <= 1'b0;
			else
				send_pixel(px, py, bg_ref(int'(px), int'(py)));
		end
		@(posedge clk);
		pixel_valid <= 1'b0;

		while (in_flight.size() != 0)
			@(posedge clk);
		repeat (3) @(posedge clk);

		if (n_checked != n_sent)
		begin
			valid_errs++;
			$display("sent %0d pixels but only %0d colours came back", n_sent, n_checked);
		end
		$display("errors: %0d rgb, %0d valid, %0d pixels checked",
				rgb_errs, valid_errs, n_checked);
		if (rgb_errs + valid_errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: files.f
hw/frogger_pkg.sv
hw/pixel_if.sv
hw/lane_hit.sv
hw/object_hit_stage.sv
hw/background_map.sv
hw/pixel_compositor.sv
hw/color_mapper.sv
tb/color_mapper_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f files.f --top-module color_mapper_tb -o color_mapper_sim --Mdir obj_dir
./obj_dir/color_mapper_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported errors, see sim.log"
	exit 1
fi
echo "simulation clean"
